//--- list.f
+incdir+rtl
rtl/uart_line_pkg.sv
rtl/uart_host_pkg.sv
rtl/uart_fifo_if.sv
rtl/uart_baud_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_fifo.sv
rtl/uart_ctrl.sv
rtl/uart_top.sv
bench/uart_properties.sv
bench/uart_tb.sv

//--- Makefile
# Verilator build for the UART subsystem and its testbench

VERILATOR   ?= verilator
FILELIST    ?= list.f
TOP         ?= uart_tb
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing --assert -j 0
ERROR_LIMIT ?= 100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/uart_tb.sv
// self-checking testbench for uart_top, drives random serial and host traffic against queue models
`timescale 1ns/1ns
`default_nettype none
`include "uart_config.svh"

module uart_tb;

   localparam int bit_cycles    = `UART_TICKS_PER_BIT * `UART_BAUD_DIV;
   localparam int frame_cycles  = (`UART_DATA_BITS + 2) * bit_cycles;
   localparam int n_tx          = 8;
   localparam int n_rx          = 8;
   localparam int n_burst       = 20;
   localparam int n_ovr         = 17;
   localparam int watchdog_cyc  = (n_tx + n_rx + n_burst + n_ovr) * frame_cycles + 40000;
   localparam logic [31:0] lfsr_taps = 32'h80200003;

   logic       clk;
   logic       reset;
   logic       rx;
   logic       tx;
   logic [7:0] tx_data;
   logic       tx_write;
   logic       tx_full;
   logic [7:0] rx_data;
   logic       rx_read;
   logic       rx_empty;
   logic       rx_overrun;

   logic [31:0] lfsr_state = 32'he0e5f002;
   logic [7:0]  exp_tx[$];   // bytes accepted by the tx FIFO, oldest first
   logic [7:0]  exp_rx[$];   // frames sent on rx that should reach rx_data
   int          checks = 0;
   int          errors = 0;

   uart_top u_uart_top (
      .clk        (clk),
      .reset      (reset),
      .rx         (rx),
      .tx         (tx),
      .tx_data    (tx_data),
      .tx_write   (tx_write),
      .tx_full    (tx_full),
      .rx_data    (rx_data),
      .rx_read    (rx_read),
      .rx_empty   (rx_empty),
      .rx_overrun (rx_overrun)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // galois shift register, one step per bit handed out
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
      end
      return v;
   endfunction

   task automatic check(input string what, input logic [7:0] got, input logic [7:0] want);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s got %02h expected %02h", $time, what, got, want);
      end
   endtask

   ////////////////////////////////////////////////
   // serial and host side drivers

   task automatic send_frame(input logic [7:0] b);
      int i;
      rx = 1'b0;
      repeat (bit_cycles) @(negedge clk);
      for (i = 0; i < 8; i++)
      begin
         rx = b[i];   // lsb goes out first
         repeat (bit_cycles) @(negedge clk);
      end
      rx = 1'b1;
      repeat (bit_cycles) @(negedge clk);
   endtask

   task automatic write_tx(input logic [7:0] b, output logic accepted);
      @(negedge clk);
      tx_data  = b;
      tx_write = 1'b1;
      accepted = !tx_full;   // full cannot change before the next rising edge
      if (accepted)
         exp_tx.push_back(b);
   endtask

   task automatic read_rx();
      int         n;
      logic [7:0] want;
      n = 0;
      while (rx_empty && n < 2 * frame_cycles)
      begin
         @(negedge clk);
         n++;
      end
      if (rx_empty)
      begin
         errors++;
         $display("no byte reached the receive FIFO in time at %0t ns", $time);
      end
      else
      begin
         want = exp_rx.pop_front();
         check("rx_data", rx_data, want);
         rx_read = 1'b1;
         @(negedge clk);
         rx_read = 1'b0;
      end
   endtask

   task automatic wait_tx_drain(input int limit);
      int n;
      n = 0;
      while (exp_tx.size() != 0 && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (exp_tx.size() != 0)
      begin
         errors++;
         $display("transmitter did not send all written bytes in time");
      end
   endtask

   // decodes tx at bit centres, one bit is bit_cycles long
   initial
   begin : tx_monitor
      logic [7:0] got;
      int         i;
      forever
      begin
         @(negedge clk);
         if (!reset && tx == 1'b0)
         begin
            repeat (bit_cycles / 2) @(negedge clk);
            check("tx start bit", 8'(tx), 8'd0);
            for (i = 0; i < 8; i++)
            begin
               repeat (bit_cycles) @(negedge clk);
               got[i] = tx;
            end
            repeat (bit_cycles) @(negedge clk);
            check("tx stop bit", 8'(tx), 8'd1);
            if (exp_tx.size() == 0)
            begin
               errors++;
               $display("byte %02h appeared on tx without being accepted", got);
            end
            else
               check("tx byte", got, exp_tx.pop_front());
         end
      end
   end

   initial
   begin
      repeat (watchdog_cyc) @(posedge clk);
      $display("watchdog expired before the tests finished");
      $display("Test FAILED");
      $finish;
   end

   ////////////////////////////////////////////////
   // test sequence

   initial
   begin
      int         k;
      int         fails;
      int         n_acc;
      logic [7:0] b;
      logic       acc;
      logic       saw_full;
      reset    = 1'b1;
      rx       = 1'b1;
      tx_data  = 8'h00;
      tx_write = 1'b0;
      rx_read  = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check("tx after reset", 8'(tx), 8'd1);
      check("rx_empty after reset", 8'(rx_empty), 8'd1);
      check("tx_full after reset", 8'(tx_full), 8'd0);
      check("rx_overrun after reset", 8'(rx_overrun), 8'd0);

      for (k = 0; k < n_tx; k++)
         write_tx(8'(take_bits(8)), acc);
      @(negedge clk);
      tx_write = 1'b0;
      wait_tx_drain((n_tx + 2) * frame_cycles);

      for (k = 0; k < n_rx; k++)
      begin
         b = 8'(take_bits(8));
         exp_rx.push_back(b);
         send_frame(b);
         read_rx();
         repeat (int'(take_bits(7))) @(negedge clk);   // idle gap
      end

      saw_full = 1'b0;
      n_acc    = 0;
      for (k = 0; k < n_burst; k++)
      begin
         write_tx(8'(take_bits(8)), acc);
         if (acc)
            n_acc++;
         else
            saw_full = 1'b1;
      end
      @(negedge clk);
      tx_write = 1'b0;
      check("tx_full seen in burst", 8'(saw_full), 8'd1);
      // the idle transmitter takes the first byte at once, then the FIFO fills up
      check("bytes accepted in burst", 8'(n_acc), 8'(2 ** `UART_FIFO_AW + 1));
      wait_tx_drain((n_burst + 2) * frame_cycles);
      repeat (2 * frame_cycles) @(negedge clk);
      check("tx idle after burst", 8'(tx), 8'd1);

      // no reads here, the last frame must be dropped
      for (k = 0; k < n_ovr; k++)
      begin
         b = 8'(take_bits(8));
         if (k < 16)
            exp_rx.push_back(b);
         send_frame(b);
         repeat (int'(take_bits(4))) @(negedge clk);
      end
      check("rx_overrun", 8'(rx_overrun), 8'd1);
      for (k = 0; k < 16; k++)
         read_rx();
      check("rx_empty after draining", 8'(rx_empty), 8'd1);

      fails = u_uart_top.u_tx_fifo.u_fifo_props.failures +
              u_uart_top.u_rx_fifo.u_fifo_props.failures +
              u_uart_top.u_tx.u_tx_props.failures;
      $display("checks %0d, check errors %0d, assertion failures %0d", checks, errors, fails);
      if (errors == 0 && fails == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/uart_properties.sv
// concurrent assertions on FIFO flags and the idle tx line, bound into uart_fifo and uart_tx
`timescale 1ns/1ns
`default_nettype none

module uart_properties (
   input wire                      clk,
   input wire                      reset,
   input wire                      full,
   input wire                      empty,
   input wire uart_host_pkg::fifo_ptr_t wr_ptr,
   input wire                      busy,
   input wire                      tx
);
   int failures = 0;

   a_flags_exclusive: assert property (@(posedge clk) disable iff (reset) !(full && empty))
   else
   begin
      failures++;
      $error("FIFO reports full and empty at the same time");
   end

   // a write while full would move the write pointer
   a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
      full |=> (wr_ptr == $past(wr_ptr)))
   else
   begin
      failures++;
      $error("FIFO was written while full");
   end

   a_idle_line_high: assert property (@(posedge clk) disable iff (reset) !busy |-> tx)
   else
   begin
      failures++;
      $error("tx is low while the transmitter is idle");
   end

endmodule

bind uart_fifo uart_properties u_fifo_props (
   .clk    (clk),
   .reset  (reset),
   .full   (bus.full),
   .empty  (bus.empty),
   .wr_ptr (wr_ptr),
   .busy   (1'b1),
   .tx     (1'b1)
);

bind uart_tx uart_properties u_tx_props (
   .clk    (clk),
   .reset  (reset),
   .full   (1'b0),
   .empty  (1'b1),
   .wr_ptr ('0),
   .busy   (busy),
   .tx     (tx)
);

`default_nettype wire

//--- rtl/uart_top.sv
// UART top level with plain host strobes and the serial pins, instantiates the whole subsystem
`timescale 1ns/1ns
`default_nettype none
`include "uart_config.svh"

module uart_top (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        rx,
   output logic                       tx,
   input  wire [`UART_DATA_BITS-1:0]  tx_data,
   input  wire                        tx_write,
   output logic                       tx_full,
   output logic [`UART_DATA_BITS-1:0] rx_data,
   input  wire                        rx_read,
   output logic                       rx_empty,
   output logic                       rx_overrun
);
   import uart_line_pkg::*;
   import uart_host_pkg::*;

   logic         tick;
   logic         rx_done;
   uart_byte_t   rx_byte;
   logic         tx_start;
   logic         tx_busy;
   uart_status_t status;

   uart_fifo_if tx_fifo_bus ();
   uart_fifo_if rx_fifo_bus ();

   // host is the writer of the tx FIFO and the reader of the rx FIFO
   assign tx_fifo_bus.wr    = tx_write;
   assign tx_fifo_bus.wdata = tx_data;
   assign rx_fifo_bus.rd    = rx_read;
   assign rx_data           = rx_fifo_bus.rdata;

   uart_baud_gen u_baud_gen (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

   uart_rx u_rx (
      .clk   (clk),
      .reset (reset),
      .tick  (tick),
      .rx    (rx),
      .done  (rx_done),
      .data  (rx_byte)
   );

   uart_tx u_tx (
      .clk   (clk),
      .reset (reset),
      .tick  (tick),
      .start (tx_start),
      .data  (tx_fifo_bus.rdata),   // head of the FIFO, latched on start
      .busy  (tx_busy),
      .tx    (tx)
   );

   uart_ctrl u_ctrl (
      .clk      (clk),
      .reset    (reset),
      .rx_done  (rx_done),
      .rx_byte  (rx_byte),
      .rx_fifo  (rx_fifo_bus.producer),
      .tx_fifo  (tx_fifo_bus.consumer),
      .tx_busy  (tx_busy),
      .tx_start (tx_start),
      .status   (status)
   );

   uart_fifo u_tx_fifo (
      .clk   (clk),
      .reset (reset),
      .bus   (tx_fifo_bus.fifo)
   );

   uart_fifo u_rx_fifo (
      .clk   (clk),
      .reset (reset),
      .bus   (rx_fifo_bus.fifo)
   );

   assign tx_full    = status.tx_full;
   assign rx_empty   = status.rx_empty;
   assign rx_overrun = status.rx_overrun;

endmodule

`default_nettype wire

//--- rtl/uart_ctrl.sv
// glue between the serial datapaths and the FIFOs, also keeps the sticky overrun flag
`timescale 1ns/1ns
`default_nettype none

module uart_ctrl (
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            rx_done,
   input  wire uart_line_pkg::uart_byte_t rx_byte,
   uart_fifo_if.producer                  rx_fifo,
   uart_fifo_if.consumer                  tx_fifo,
   input  wire                            tx_busy,
   output logic                           tx_start,
   output uart_host_pkg::uart_status_t    status
);
   logic rx_push;   // done pulse delayed by one cycle
   logic overrun;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rx_push <= 1'b0;
         overrun <= 1'b0;
      end
      else
      begin
         rx_push <= rx_done;
         // a byte that finds the FIFO full is lost, remember that until reset
         if (rx_push && rx_fifo.full)
            overrun <= 1'b1;
      end
   end

   ////////////////////////////////////////////////
   // receive side

   assign rx_fifo.wr    = rx_push & ~rx_fifo.full;
   assign rx_fifo.wdata = rx_byte;   // stays valid until the next done

   ////////////////////////////////////////////////
   // transmit side

   // busy rises on the edge that takes start, so this launches once per byte
   assign tx_start   = ~tx_busy & ~tx_fifo.empty;
   assign tx_fifo.rd = tx_start;

   assign status.tx_full    = tx_fifo.full;
   assign status.rx_empty   = rx_fifo.empty;
   assign status.rx_overrun = overrun;

endmodule

`default_nettype wire

//--- rtl/uart_fifo.sv
// show-ahead byte FIFO built on a register array, one per direction
`timescale 1ns/1ns
`default_nettype none
`include "uart_config.svh"

module uart_fifo (
   input  wire           clk,
   input  wire           reset,
   uart_fifo_if.fifo     bus
);
   import uart_line_pkg::*;
   import uart_host_pkg::*;

   localparam int depth = 2 ** `UART_FIFO_AW;

   uart_byte_t mem [depth];
   fifo_ptr_t  wr_ptr;
   fifo_ptr_t  rd_ptr;
   logic       push;
   logic       pop;

   assign push = bus.wr & ~bus.full;
   assign pop  = bus.rd & ~bus.empty;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr[`UART_FIFO_AW-1:0]] <= bus.wdata;
   end

   // same index with different wrap bits means the writer lapped the reader
   assign bus.empty = (wr_ptr == rd_ptr);
   assign bus.full  = (wr_ptr[`UART_FIFO_AW] != rd_ptr[`UART_FIFO_AW]) &&
                      (wr_ptr[`UART_FIFO_AW-1:0] == rd_ptr[`UART_FIFO_AW-1:0]);
   assign bus.rdata = mem[rd_ptr[`UART_FIFO_AW-1:0]];

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
// serial transmitter, sends one latched byte as start bit, 8 data bits lsb first and stop bit
`timescale 1ns/1ns
`default_nettype none
`include "uart_config.svh"

module uart_tx (
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            tick,
   input  wire                            start,
   input  wire uart_line_pkg::uart_byte_t data,
   output logic                           busy,
   output logic                           tx
);
   import uart_line_pkg::*;

   localparam int tw = $clog2(`UART_TICKS_PER_BIT);
   localparam int nw = $clog2(`UART_DATA_BITS);
   localparam logic [tw-1:0] last_tick = tw'(`UART_TICKS_PER_BIT - 1);
   localparam logic [tw-1:0] stop_last = tw'(`UART_STOP_TICKS - 1);
   localparam logic [nw-1:0] last_bit  = nw'(`UART_DATA_BITS - 1);

   tx_state_t     state_reg, state_next;
   logic [tw-1:0] s_reg, s_next;
   logic [nw-1:0] n_reg, n_next;
   uart_byte_t    b_reg, b_next;
   logic          tx_reg, tx_next;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state_reg <= tx_st_idle;
         s_reg     <= '0;
         n_reg     <= '0;
         tx_reg    <= 1'b1;   // line idles high
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
         tx_reg    <= tx_next;
      end
   end

   always_ff @(posedge clk)
   begin
      b_reg <= b_next;
   end

   ////////////////////////////////////////////////
   // bit sequencing, the line only changes on a tick

   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      tx_next    = tx_reg;
      case (state_reg)
         tx_st_idle:
            if (start)
            begin
               state_next = tx_st_start;
               s_next     = '0;
               b_next     = data;
            end
         tx_st_start:
            if (tick)
            begin
               // line still high means this is the first tick, open the start bit here
               if (tx_reg)
               begin
                  tx_next = 1'b0;
                  s_next  = '0;
               end
               else if (s_reg == last_tick)
               begin
                  state_next = tx_st_data;
                  s_next     = '0;
                  n_next     = '0;
                  tx_next    = b_reg[0];
               end
               else
                  s_next = s_reg + 1'b1;
            end
         tx_st_data:
            if (tick)
            begin
               if (s_reg == last_tick)
               begin
                  s_next = '0;
                  if (n_reg == last_bit)
                  begin
                     state_next = tx_st_stop;
                     tx_next    = 1'b1;
                  end
                  else
                  begin
                     n_next  = n_reg + 1'b1;
                     b_next  = b_reg >> 1;
                     tx_next = b_reg[1];   // next bit after the shift
                  end
               end
               else
                  s_next = s_reg + 1'b1;
            end
         tx_st_stop:
            if (tick)
            begin
               if (s_reg == stop_last)
                  state_next = tx_st_idle;
               else
                  s_next = s_reg + 1'b1;
            end
         default:
            state_next = tx_st_idle;
      endcase
   end

   assign busy = (state_reg != tx_st_idle);
   assign tx   = tx_reg;

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
// oversampling serial receiver, turns one 8N1 frame on rx into a byte and a done pulse
`timescale 1ns/1ns
`default_nettype none
`include "uart_config.svh"

module uart_rx (
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       tick,
   input  wire                       rx,
   output logic                      done,
   output uart_line_pkg::uart_byte_t data
);
   import uart_line_pkg::*;

   localparam int tw = $clog2(`UART_TICKS_PER_BIT);
   localparam int nw = $clog2(`UART_DATA_BITS);
   localparam logic [tw-1:0] mid_tick  = tw'(`UART_TICKS_PER_BIT / 2 - 1);
   localparam logic [tw-1:0] last_tick = tw'(`UART_TICKS_PER_BIT - 1);
   localparam logic [tw-1:0] stop_last = tw'(`UART_STOP_TICKS - 1);
   localparam logic [nw-1:0] last_bit  = nw'(`UART_DATA_BITS - 1);

   rx_state_t     state_reg, state_next;
   logic [tw-1:0] s_reg, s_next;   // ticks within the current bit
   logic [nw-1:0] n_reg, n_next;   // data bits taken so far
   uart_byte_t    b_reg, b_next;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state_reg <= rx_st_idle;
         s_reg     <= '0;
         n_reg     <= '0;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
      end
   end

   always_ff @(posedge clk)
   begin
      b_reg <= b_next;
   end

   ////////////////////////////////////////////////
   // next-state logic

   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      done       = 1'b0;
      case (state_reg)
         rx_st_idle:
            if (!rx)   // falling edge of the start bit
            begin
               state_next = rx_st_start;
               s_next     = '0;
            end
         rx_st_start:
            if (tick)
            begin
               // middle of the start bit, from here every bit is a full period away
               if (s_reg == mid_tick)
               begin
                  state_next = rx_st_data;
                  s_next     = '0;
                  n_next     = '0;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         rx_st_data:
            if (tick)
            begin
               if (s_reg == last_tick)
               begin
                  s_next = '0;
                  b_next = {rx, b_reg[`UART_DATA_BITS-1:1]};   // lsb arrives first
                  if (n_reg == last_bit)
                     state_next = rx_st_stop;
                  else
                     n_next = n_reg + 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         rx_st_stop:
            if (tick)
            begin
               if (s_reg == stop_last)
               begin
                  state_next = rx_st_idle;
                  done       = 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         default:
            state_next = rx_st_idle;
      endcase
   end

   assign data = b_reg;   // held until the next frame completes

endmodule

`default_nettype wire

//--- rtl/uart_baud_gen.sv
// free-running divider that gives the receiver and transmitter their oversampling tick
`timescale 1ns/1ns
`default_nettype none
`include "uart_config.svh"

module uart_baud_gen (
   input  wire  clk,
   input  wire  reset,
   output logic tick
);
   localparam int cw = $clog2(`UART_BAUD_DIV);
   localparam logic [cw-1:0] last_cnt = cw'(`UART_BAUD_DIV - 1);

   logic [cw-1:0] cnt;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         cnt <= '0;
      else if (cnt == last_cnt)
         cnt <= '0;
      else
         cnt <= cnt + 1'b1;
   end

   assign tick = (cnt == last_cnt);   // one cycle per wrap

endmodule

`default_nettype wire

//--- rtl/uart_fifo_if.sv
// write, read and flag signals of one byte FIFO, shared by its producer and consumer
`timescale 1ns/1ns
`default_nettype none

interface uart_fifo_if;
   import uart_line_pkg::*;

   logic       wr;
   uart_byte_t wdata;
   logic       full;
   logic       rd;
   uart_byte_t rdata;   // always the oldest entry
   logic       empty;

   // both sides may watch both flags, only the FIFO drives them
   modport producer (output wr, wdata, input full, empty);
   modport consumer (output rd, input rdata, empty, full);
   modport fifo (input wr, wdata, rd, output rdata, full, empty);

endinterface

`default_nettype wire

//--- rtl/uart_host_pkg.sv
// host-side types for FIFO bookkeeping and the status word seen by the host
`default_nettype none
`include "uart_config.svh"

package uart_host_pkg;

   typedef logic [`UART_FIFO_AW:0] fifo_ptr_t;   // msb is the wrap bit

   typedef struct packed {
      logic tx_full;
      logic rx_empty;
      logic rx_overrun;
   } uart_status_t;

endpackage

`default_nettype wire

//--- rtl/uart_line_pkg.sv
// serial-side types shared by the receiver, the transmitter and the FIFO data path
`default_nettype none
`include "uart_config.svh"

package uart_line_pkg;

   typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

   typedef enum logic [1:0] {
      rx_st_idle,
      rx_st_start,
      rx_st_data,
      rx_st_stop
   } rx_state_t;

   typedef enum logic [1:0] {
      tx_st_idle,
      tx_st_start,
      tx_st_data,
      tx_st_stop
   } tx_state_t;

endpackage

`default_nettype wire

//--- rtl/uart_config.svh
// build-time constants for the UART, included by the packages and by any RTL that sizes logic
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// serial frame format, 8N1 with 16x oversampling
`define UART_DATA_BITS     8
`define UART_TICKS_PER_BIT 16
`define UART_STOP_TICKS    16

// clock cycles per oversampling tick, so one bit takes 64 cycles
`define UART_BAUD_DIV      4

`define UART_FIFO_AW       4   // 16 entries per FIFO

`endif
